/* kcpu_trace.txt */
# C op rsel idx postbyte data, then expected a b dp cc x y u s ea after the command (hex)
# D addr data queues a host write raised during the next command, R addr byte is a host read
C 1 0 0 00 ab11 11 00 00 00 0000 0000 0000 0000 0000
C 1 1 0 00 0022 11 22 00 00 0000 0000 0000 0000 0000
C 1 6 0 00 0033 11 22 33 00 0000 0000 0000 0000 0000
C 1 7 0 00 0044 11 22 33 44 0000 0000 0000 0000 0000
C 1 2 0 00 1234 11 22 33 44 1234 0000 0000 0000 0000
C 1 3 0 00 5678 11 22 33 44 1234 5678 0000 0000 0000
C 1 5 0 00 9abc 11 22 33 44 1234 5678 9abc 0000 0000
C 1 4 0 00 0300 11 22 33 44 1234 5678 9abc 0300 0000
C 2 0 0 23 0000 11 22 33 44 1234 1234 9abc 0300 0000
C 2 0 0 02 0000 11 22 33 44 0011 1234 9abc 0300 0000
C 2 0 0 51 0000 11 bc 33 44 0011 1234 9abc 0300 0000
C 3 0 0 01 0000 bc 11 33 44 0011 1234 9abc 0300 0000
C 3 0 0 25 0000 bc 11 33 44 9abc 1234 0011 0300 0000
C 3 0 0 63 0000 bc 11 34 44 9abc 0033 0011 0300 0000
C 4 2 0 00 0000 bc 11 34 44 9abd 0033 0011 0300 9abc
C 4 3 1 00 0000 bc 11 34 44 9abd 0035 0011 0300 0033
C 4 5 2 00 0000 bc 11 34 44 9abd 0035 0010 0300 0010
C 4 4 3 00 0000 bc 11 34 44 9abd 0035 0010 02fe 02fe
D 0100 5a
C 5 4 0 ff 0000 bc 11 34 44 9abd 0035 0010 02f4 02fe
R 02fd 10
R 02fc 00
R 02fb 35
R 02fa 00
R 02f9 bd
R 02f8 9a
R 02f7 34
R 02f6 11
R 02f5 bc
R 02f4 44
R 0100 5a
C 1 0 0 00 0000 00 11 34 44 9abd 0035 0010 02f4 02fe
C 2 0 0 01 0000 00 00 34 44 9abd 0035 0010 02f4 02fe
C 2 0 0 06 0000 00 00 00 44 9abd 0035 0010 02f4 02fe
C 2 0 0 07 0000 00 00 00 00 9abd 0035 0010 02f4 02fe
C 2 0 0 02 0000 00 00 00 00 0000 0035 0010 02f4 02fe
C 2 0 0 03 0000 00 00 00 00 0000 0000 0010 02f4 02fe
C 2 0 0 05 0000 00 00 00 00 0000 0000 0000 02f4 02fe
C 6 4 0 ff 0000 bc 11 34 44 9abd 0035 0010 02fe 02fe

/* files.f */
kcpu_pkg.sv
kcpu_ram.sv
kcpu_bus_arb.sv
kcpu_regs.sv
kcpu_stack.sv
kcpu_sub.sv
kcpu_checker.sv
kcpu_sva.sv
kcpu_tb.sv

/* kcpu_tb.sv */
// kcpu testbench top: trace-driven commands and host accesses with a cycle watchdog
`timescale 1ns/1ps

module kcpu_tb;
    import kcpu_pkg::*;

    logic          clk;
    logic          rst;
    logic          cmd_stb;
    kcpu_cmd_t     cmd;
    kcpu_mem_req_t host_req;
    logic          busy;
    kcpu_regs_t    regs;
    logic [15:0]   ea;
    logic          host_gnt;
    logic [7:0]    host_rdata;

    kcpu_regs_t    exp_regs;
    logic [15:0]   exp_ea;
    logic [7:0]    exp_byte;
    logic          rd_check;   // next host grant is a read to compare
    logic          gnt_idle;   // next host grant must come with busy low
    logic          wr_pend;
    logic [15:0]   wr_addr;
    logic [7:0]    wr_data;
    int            chk_errors;
    int            seq_errors = 0;
    int            cycles = 0;
    int            limit = 1000;
    string         lines[$];
    byte           kind;
    string         rest;

    kcpu_sub #(.ADDR_W(10)) UUT (
        .clk        (clk),
        .rst        (rst),
        .cmd_stb    (cmd_stb),
        .cmd        (cmd),
        .host_req   (host_req),
        .busy       (busy),
        .regs       (regs),
        .ea         (ea),
        .host_gnt   (host_gnt),
        .host_rdata (host_rdata)
    );

    kcpu_checker chk (
        .clk        (clk),
        .rst        (rst),
        .cmd_stb    (cmd_stb),
        .busy       (busy),
        .regs       (regs),
        .ea         (ea),
        .host_gnt   (host_gnt),
        .host_rdata (host_rdata),
        .exp_regs   (exp_regs),
        .exp_ea     (exp_ea),
        .exp_byte   (exp_byte),
        .rd_check   (rd_check),
        .gnt_idle   (gnt_idle),
        .errors     (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: no end of trace after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic read_trace();
        int    fd;
        int    rc;
        string line;
        fd = $fopen("kcpu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open kcpu_trace.txt");
            seq_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 1 && line.getc(0) != "#")
                lines.push_back(line);
        end
        $fclose(fd);
    endtask

    // one command strobe, then wait for the stack engine to go idle
    task automatic run_cmd(string txt);
        int f[14];
        int n;
        n = $sscanf(txt, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                    f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        if (n != 14) begin
            $display("malformed command line in trace: %s", txt);
            seq_errors++;
            return;
        end
        @(negedge clk);
        cmd      = {f[0][2:0], f[1][2:0], f[2][1:0], f[3][7:0], f[4][15:0]};
        exp_regs = {f[5][7:0], f[6][7:0], f[7][7:0], f[8][7:0],
                    f[9][15:0], f[10][15:0], f[11][15:0], f[12][15:0]};
        exp_ea   = f[13][15:0];
        cmd_stb  = 1'b1;
        @(negedge clk);
        cmd_stb = 1'b0;
        if (wr_pend) begin // busy is already up here, so the host has to wait
            gnt_idle = 1'b1;
            rd_check = 1'b0;
            host_req = '{req: 1'b1, we: 1'b1, addr: wr_addr, wdata: wr_data};
        end
        while (busy)
            @(negedge clk);
        if (wr_pend) begin
            while (!host_gnt)
                @(negedge clk);
            host_req.req = 1'b0;
            wr_pend      = 1'b0;
        end
    endtask

    task automatic queue_write(string txt);
        int ad;
        int dt;
        if ($sscanf(txt, "%h %h", ad, dt) != 2) begin
            $display("malformed host write line in trace: %s", txt);
            seq_errors++;
            return;
        end
        wr_pend = 1'b1;
        wr_addr = ad[15:0];
        wr_data = dt[7:0];
    endtask

    task automatic host_read(string txt);
        int ad;
        int eb;
        if ($sscanf(txt, "%h %h", ad, eb) != 2) begin
            $display("malformed host read line in trace: %s", txt);
            seq_errors++;
            return;
        end
        @(negedge clk);
        gnt_idle = 1'b0;
        rd_check = 1'b1;
        exp_byte = eb[7:0];
        host_req = '{req: 1'b1, we: 1'b0, addr: ad[15:0], wdata: 8'h00};
        while (!host_gnt)
            @(negedge clk);
        host_req.req = 1'b0;
    endtask

    initial begin
        rst      = 1'b1;
        cmd_stb  = 1'b0;
        cmd      = '0;
        host_req = '0;
        exp_regs = '0;
        exp_ea   = '0;
        exp_byte = '0;
        rd_check = 1'b0;
        gnt_idle = 1'b0;
        wr_pend  = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        read_trace();
        limit = 40 * (lines.size() + 1);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (lines[i]) begin
            kind = lines[i].getc(0);
            rest = lines[i].substr(1, lines[i].len() - 1);
            case (kind)
                "C": run_cmd(rest);
                "D": queue_write(rest);
                "R": host_read(rest);
                default: begin
                    $display("unknown trace line: %s", lines[i]);
                    seq_errors++;
                end
            endcase
        end
        repeat (4) @(negedge clk); // let the last compare happen
        $display("checker errors %0d, assertion errors %0d, trace errors %0d",
                 chk_errors, UUT.sva_i.fail_count, seq_errors);
        if (chk_errors == 0 && UUT.sva_i.fail_count == 0 && seq_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* kcpu_sva.sv */
// kcpu bound assertions on command strobe, busy and RAM grant rules
`timescale 1ns/1ps

module kcpu_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    cmd_stb,
    input logic                    busy,
    input logic                    stk_gnt,
    input logic                    host_gnt,
    input kcpu_pkg::kcpu_mem_req_t host_req
);

    int fail_count = 0;

    strobe_idle: assert property (@(posedge clk) disable iff (rst) cmd_stb |-> !busy)
        else begin
            $error("command strobe while busy");
            fail_count++;
        end

    gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0({stk_gnt, host_gnt}))
        else begin
            $error("stack and host granted together");
            fail_count++;
        end

    // request may only drop once the grant pulse is seen
    host_hold: assert property (@(posedge clk) disable iff (rst)
        host_req.req && !host_gnt |=> host_req.req || host_gnt)
        else begin
            $error("host request dropped before grant");
            fail_count++;
        end

    idle_after_rst: assert property (@(posedge clk) $fell(rst) |-> !busy)
        else begin
            $error("busy set right after reset");
            fail_count++;
        end

endmodule

bind kcpu_sub kcpu_sva sva_i (
    .clk      (clk),
    .rst      (rst),
    .cmd_stb  (cmd_stb),
    .busy     (busy),
    .stk_gnt  (stk_gnt),
    .host_gnt (host_gnt),
    .host_req (host_req)
);

/* kcpu_checker.sv */
// kcpu checker: compares register state, ea and host read data with trace values
`timescale 1ns/1ps

module kcpu_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_stb,
    input  logic                 busy,
    input  kcpu_pkg::kcpu_regs_t regs,
    input  logic [15:0]          ea,
    input  logic                 host_gnt,
    input  logic [7:0]           host_rdata,
    input  kcpu_pkg::kcpu_regs_t exp_regs,
    input  logic [15:0]          exp_ea,
    input  logic [7:0]           exp_byte,
    input  logic                 rd_check,
    input  logic                 gnt_idle,
    output int                   errors
);
    import kcpu_pkg::*;

    kcpu_regs_t  exp_l;
    logic [15:0] ea_l;
    logic [7:0]  byte_l;
    logic        cmd_pend;  // command seen, result not yet compared
    logic        rd_pend;

    initial errors = 0;

    task automatic compare(string name, logic [15:0] got, logic [15:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_pend <= 1'b0;
            rd_pend  <= 1'b0;
        end else begin
            // first idle edge after the strobe
            if (cmd_pend && !busy) begin
                compare("regs.a", {8'h00, regs.a}, {8'h00, exp_l.a});
                compare("regs.b", {8'h00, regs.b}, {8'h00, exp_l.b});
                compare("regs.dp", {8'h00, regs.dp}, {8'h00, exp_l.dp});
                compare("regs.cc", {8'h00, regs.cc}, {8'h00, exp_l.cc});
                compare("regs.x", regs.x, exp_l.x);
                compare("regs.y", regs.y, exp_l.y);
                compare("regs.u", regs.u, exp_l.u);
                compare("regs.s", regs.s, exp_l.s);
                compare("ea", ea, ea_l);
                cmd_pend <= 1'b0;
            end
            if (cmd_stb) begin
                cmd_pend <= 1'b1;
                exp_l    <= exp_regs;
                ea_l     <= exp_ea;
            end
            if (rd_pend) begin
                compare("host_rdata", {8'h00, host_rdata}, {8'h00, byte_l});
                rd_pend <= 1'b0;
            end
            if (host_gnt && rd_check) begin // data follows one cycle later
                rd_pend <= 1'b1;
                byte_l  <= exp_byte;
            end
            if (host_gnt && gnt_idle && busy) begin
                $display("host write was granted at %0t while the stack engine was busy", $time);
                errors++;
            end
        end
    end

endmodule

/* kcpu_sub.sv */
// kcpu register subsystem top: register file, stack engine, arbiter and RAM
`timescale 1ns/1ps

module kcpu_sub #(
    parameter int ADDR_W = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_stb,
    input  kcpu_pkg::kcpu_cmd_t     cmd,
    input  kcpu_pkg::kcpu_mem_req_t host_req,
    output logic                    busy,
    output kcpu_pkg::kcpu_regs_t    regs,
    output logic [15:0]             ea,
    output logic                    host_gnt,
    output logic [7:0]              host_rdata
);
    import kcpu_pkg::*;

    kcpu_mem_req_t     stk_req;
    logic              stk_gnt;
    kcpu_wb_t          wb;
    logic              sp_dec;
    logic              sp_inc;
    logic              sp_sel_u;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    logic [7:0]        ram_wdata;
    logic [7:0]        ram_rdata;

    assign host_rdata = ram_rdata; // shared read bus

    kcpu_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cmd_stb  (cmd_stb),
        .cmd      (cmd),
        .wb       (wb),
        .sp_dec   (sp_dec),
        .sp_inc   (sp_inc),
        .sp_sel_u (sp_sel_u),
        .regs     (regs),
        .ea       (ea)
    );

    kcpu_stack u_stack (
        .clk      (clk),
        .rst      (rst),
        .cmd_stb  (cmd_stb),
        .cmd      (cmd),
        .regs     (regs),
        .gnt      (stk_gnt),
        .rdata    (ram_rdata),
        .mem      (stk_req),
        .busy     (busy),
        .wb       (wb),
        .sp_dec   (sp_dec),
        .sp_inc   (sp_inc),
        .sp_sel_u (sp_sel_u)
    );

    kcpu_bus_arb #(.ADDR_W(ADDR_W)) u_arb (
        .clk       (clk),
        .rst       (rst),
        .stk_req   (stk_req),
        .host_req  (host_req),
        .stk_gnt   (stk_gnt),
        .host_gnt  (host_gnt),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    kcpu_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* kcpu_stack.sv */
// kcpu push/pull sequencer, one stack byte per granted memory cycle
`timescale 1ns/1ps

module kcpu_stack (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_stb,
    input  kcpu_pkg::kcpu_cmd_t     cmd,
    input  kcpu_pkg::kcpu_regs_t    regs,
    input  logic                    gnt,
    input  logic [7:0]              rdata,
    output kcpu_pkg::kcpu_mem_req_t mem,
    output logic                    busy,
    output kcpu_pkg::kcpu_wb_t      wb,
    output logic                    sp_dec,
    output logic                    sp_inc,
    output logic                    sp_sel_u
);
    import kcpu_pkg::*;

    kcpu_pb_mask_t mask;
    logic          is_pul;
    logic          half;     // first byte of a 16-bit register already moved
    logic          start;
    logic [2:0]    sel;
    kcpu_reg_e     code;
    logic          wide;
    logic [15:0]   val;
    logic [15:0]   sp;
    logic          rd_en;
    kcpu_reg_e     rd_rsel;
    logic          rd_hi;

    assign start = cmd_stb && (cmd.op == PSH || cmd.op == PUL);
    assign sp    = sp_sel_u ? regs.u : regs.s;

    // push walks from bit 6 down, pull from bit 0 up
    always_comb begin
        sel = 3'd0;
        if (is_pul) begin
            for (int i = 6; i >= 0; i--)
                if (mask[i]) sel = 3'(i);
        end else begin
            for (int i = 0; i <= 6; i++)
                if (mask[i]) sel = 3'(i);
        end
    end

    always_comb begin
        case (sel)
            3'd0:    code = REG_CC;
            3'd1:    code = REG_A;
            3'd2:    code = REG_B;
            3'd3:    code = REG_DP;
            3'd4:    code = REG_X;
            3'd5:    code = REG_Y;
            default: code = sp_sel_u ? REG_S : REG_U; // the other stack pointer
        endcase
    end

    assign wide = sel >= 3'd4;
    assign val  = get_reg(regs, code);

    always_comb begin
        mem.req   = busy && (mask[6:0] != 7'd0);
        mem.we    = !is_pul;
        mem.addr  = is_pul ? sp : sp - 16'd1; // push writes below the pointer
        mem.wdata = (wide && half) ? val[15:8] : val[7:0];
    end

    assign sp_dec = gnt && !is_pul;
    assign sp_inc = gnt && is_pul;
    assign wb     = '{en: rd_en, rsel: rd_rsel, hi: rd_hi, data: rdata};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            mask     <= '0;
            is_pul   <= 1'b0;
            sp_sel_u <= 1'b0;
            half     <= 1'b0;
            rd_en    <= 1'b0;
        end else begin
            rd_en <= is_pul && gnt; // ram data is back one cycle after the grant
            if (start) begin
                busy     <= 1'b1;
                mask     <= cmd.pb.mask;
                mask.pc  <= 1'b0;
                is_pul   <= cmd.op == PUL;
                sp_sel_u <= cmd.rsel != REG_S;
                half     <= 1'b0;
            end else if (gnt) begin
                if (wide && !half) begin
                    half <= 1'b1;
                end else begin
                    half <= 1'b0;
                    mask <= mask & ~(8'h01 << sel);
                end
            end else if (busy && mask[6:0] == 7'd0 && !rd_en) begin
                busy <= 1'b0;
            end
        end
    end

    // read pipeline stage, tags the returning byte
    always_ff @(posedge clk) begin
        if (gnt) begin
            rd_rsel <= code;
            rd_hi   <= wide && !half;
        end
    end

endmodule

/* kcpu_regs.sv */
// kcpu register file with load, transfer, exchange, indexed step and pull write-back
`timescale 1ns/1ps

module kcpu_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_stb,
    input  kcpu_pkg::kcpu_cmd_t  cmd,
    input  kcpu_pkg::kcpu_wb_t   wb,
    input  logic                 sp_dec,
    input  logic                 sp_inc,
    input  logic                 sp_sel_u,
    output kcpu_pkg::kcpu_regs_t regs,
    output logic [15:0]          ea
);
    import kcpu_pkg::*;

    kcpu_regs_t  nx;
    logic [15:0] ea_nx;
    logic        is_ptr;
    logic        is_pre;
    logic [15:0] step;
    logic [15:0] src_v;
    logic [15:0] dst_v;
    logic [15:0] old_v;
    logic [15:0] sp_v;
    logic [15:0] wb_old;

    // 8-bit targets keep only the low byte
    function automatic kcpu_regs_t put_reg(kcpu_regs_t r, kcpu_reg_e code, logic [15:0] v);
        kcpu_regs_t o;
        o = r;
        case (code)
            REG_A:   o.a  = v[7:0];
            REG_B:   o.b  = v[7:0];
            REG_X:   o.x  = v;
            REG_Y:   o.y  = v;
            REG_S:   o.s  = v;
            REG_U:   o.u  = v;
            REG_DP:  o.dp = v[7:0];
            default: o.cc = v[7:0];
        endcase
        return o;
    endfunction

    assign is_ptr = cmd.rsel inside {REG_X, REG_Y, REG_U, REG_S};
    assign is_pre = cmd.idx inside {IDX_DEC1, IDX_DEC2};

    always_comb begin
        case (cmd.idx)
            IDX_INC1: step = 16'h0001;
            IDX_INC2: step = 16'h0002;
            IDX_DEC1: step = 16'hffff;
            default:  step = 16'hfffe;
        endcase
    end

    assign src_v  = get_reg(regs, cmd.pb.pair.src);
    assign dst_v  = get_reg(regs, cmd.pb.pair.dst);
    assign old_v  = get_reg(regs, cmd.rsel);
    assign sp_v   = sp_sel_u ? regs.u : regs.s;
    assign wb_old = get_reg(regs, wb.rsel);

    always_comb begin
        nx    = regs;
        ea_nx = ea;
        if (cmd_stb) begin
            case (cmd.op)
                LOAD: nx = put_reg(nx, cmd.rsel, cmd.data);
                TFR:  nx = put_reg(nx, cmd.pb.pair.dst, src_v);
                EXG: begin
                    nx = put_reg(nx, cmd.pb.pair.dst, src_v);
                    nx = put_reg(nx, cmd.pb.pair.src, dst_v);
                end
                IDX: begin
                    if (is_ptr) begin
                        nx    = put_reg(nx, cmd.rsel, old_v + step);
                        ea_nx = is_pre ? old_v + step : old_v;
                    end
                end
                default: ;
            endcase
        end

        // stack engine side, never active together with a command strobe
        if (sp_dec || sp_inc) begin
            if (sp_sel_u)
                nx.u = sp_inc ? sp_v + 16'd1 : sp_v - 16'd1;
            else
                nx.s = sp_inc ? sp_v + 16'd1 : sp_v - 16'd1;
        end
        if (wb.en) begin
            if (wb.hi)
                nx = put_reg(nx, wb.rsel, {wb.data, wb_old[7:0]});
            else
                nx = put_reg(nx, wb.rsel, {wb_old[15:8], wb.data});
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '0;
            ea   <= '0;
        end else begin
            regs <= nx;
            ea   <= ea_nx;
        end
    end

endmodule

/* kcpu_bus_arb.sv */
// kcpu fixed-priority RAM arbiter, stack engine ahead of the host port
`timescale 1ns/1ps

module kcpu_bus_arb #(
    parameter int ADDR_W = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  kcpu_pkg::kcpu_mem_req_t stk_req,
    input  kcpu_pkg::kcpu_mem_req_t host_req,
    output logic                    stk_gnt,
    output logic                    host_gnt,
    output logic                    ram_we,
    output logic [ADDR_W-1:0]       ram_addr,
    output logic [7:0]              ram_wdata
);
    logic stk_win;
    logic host_win;

    // a requester holding its grant pulse is not served twice for one request
    assign stk_win  = stk_req.req && !stk_gnt;
    assign host_win = host_req.req && !stk_req.req && !host_gnt; // host waits on any stack request

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stk_gnt  <= 1'b0;
            host_gnt <= 1'b0;
            ram_we   <= 1'b0;
        end else begin
            stk_gnt  <= stk_win;
            host_gnt <= host_win;
            ram_we   <= (stk_win && stk_req.we) || (host_win && host_req.we);
        end
    end

    // access reaches the ram in the grant cycle, read data follows one cycle later
    always_ff @(posedge clk) begin
        if (stk_req.req) begin
            ram_addr  <= stk_req.addr[ADDR_W-1:0];
            ram_wdata <= stk_req.wdata;
        end else begin
            ram_addr  <= host_req.addr[ADDR_W-1:0];
            ram_wdata <= host_req.wdata;
        end
    end

endmodule

/* kcpu_ram.sv */
// kcpu byte-wide synchronous RAM with registered read data
`timescale 1ns/1ps

module kcpu_ram #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);
    logic [7:0] mem [0:(1 << ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr]; // old data on a same-cycle write
    end

endmodule

/* kcpu_pkg.sv */
// kcpu shared types for the register file, stack engine and memory arbiter
package kcpu_pkg;

    typedef enum logic [2:0] {
        NOP  = 3'd0,
        LOAD = 3'd1,
        TFR  = 3'd2,
        EXG  = 3'd3,
        IDX  = 3'd4,
        PSH  = 3'd5,
        PUL  = 3'd6
    } kcpu_op_e;

    // 6809 transfer/exchange register codes
    typedef enum logic [2:0] {
        REG_A  = 3'd0,
        REG_B  = 3'd1,
        REG_X  = 3'd2,
        REG_Y  = 3'd3,
        REG_S  = 3'd4,
        REG_U  = 3'd5,
        REG_DP = 3'd6,
        REG_CC = 3'd7
    } kcpu_reg_e;

    typedef struct packed {
        logic      spare_s;
        kcpu_reg_e src;
        logic      spare_d;
        kcpu_reg_e dst;
    } kcpu_pb_pair_t;

    typedef struct packed {
        logic pc;     // reserved, never stacked here
        logic other;  // U when stacking on S, S when stacking on U
        logic y;
        logic x;
        logic dp;
        logic b;
        logic a;
        logic cc;
    } kcpu_pb_mask_t;

    typedef union packed {
        kcpu_pb_pair_t pair;
        kcpu_pb_mask_t mask;
    } kcpu_postbyte_u;

    typedef enum logic [1:0] {
        IDX_INC1 = 2'd0,
        IDX_INC2 = 2'd1,
        IDX_DEC1 = 2'd2,
        IDX_DEC2 = 2'd3
    } kcpu_idx_mode_e;

    typedef struct packed {
        kcpu_op_e       op;
        kcpu_reg_e      rsel;  // psh/pul: S selects the S stack, anything else U
        kcpu_idx_mode_e idx;
        kcpu_postbyte_u pb;
        logic [15:0]    data;
    } kcpu_cmd_t;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  dp;
        logic [7:0]  cc;
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] u;
        logic [15:0] s;
    } kcpu_regs_t;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } kcpu_mem_req_t;

    typedef struct packed {
        logic       en;
        kcpu_reg_e  rsel;
        logic       hi;    // byte goes to the upper half of a 16-bit register
        logic [7:0] data;
    } kcpu_wb_t;

    // register read by code, 8-bit registers come back zero-extended
    function automatic logic [15:0] get_reg(kcpu_regs_t r, kcpu_reg_e code);
        logic [15:0] v;
        case (code)
            REG_A:   v = {8'h00, r.a};
            REG_B:   v = {8'h00, r.b};
            REG_X:   v = r.x;
            REG_Y:   v = r.y;
            REG_S:   v = r.s;
            REG_U:   v = r.u;
            REG_DP:  v = {8'h00, r.dp};
            default: v = {8'h00, r.cc};
        endcase
        return v;
    endfunction

endpackage
